//--- include/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// primary opcode field values
`define OP_RTYPE    6'h00
`define OP_J        6'h02
`define OP_JAL      6'h03
`define OP_BEQ      6'h04
`define OP_ORI      6'h0d
`define OP_LUI      6'h0f
// signed half-word load
`define OP_LH       6'h21
`define OP_LW       6'h23
`define OP_SW       6'h2b

// funct values under the r-type opcode
`define FN_SLL      6'h00
`define FN_JR       6'h08
`define FN_ADD      6'h20
`define FN_ADDU     6'h21
`define FN_SUB      6'h22
`define FN_SUBU     6'h23

// instruction field positions
`define FIELD_OPT_HI    31
`define FIELD_OPT_LO    26
`define FIELD_FUNCT_HI  5
`define FIELD_FUNCT_LO  0
// low bit of each 5-bit register field
`define FIELD_RS        21
`define FIELD_RT        16
`define FIELD_RD        11

// link register for jal
`define REG_RA      5'd31

`endif

//--- logic/cpu_pkg.sv
package cpu_pkg;

    // raw instruction word
    typedef logic [31:0] instr_t;
    // register file index
    typedef logic [4:0]  reg_idx_t;

    // cycles until result is ready, 0 means now
    typedef logic [1:0]  tnew_t;
    // cycles until operand is needed, 3 means never
    typedef logic [1:0]  tuse_t;

    // 0 pc+4, 1 branch target, 2 jr, 3 jump
    typedef logic [1:0]  npc_sel_t;
    // 0 unsigned, 1 signed, 2 to-high
    typedef logic [1:0]  ext_op_t;
    // 0 add, 1 sub, 2 or, 3 shift left
    typedef logic [1:0]  alu_op_t;
    // 0 alu result, 1 memory read, 2 immediate, 3 pc+4
    typedef logic [1:0]  regw_src_t;
    // 0 word, 1 signed half
    typedef logic [1:0]  width_t;
    // 0 register file, 1 execute, 2 memory, 3 writeback
    typedef logic [1:0]  fwd_sel_t;

    // decoded control bundle for one instruction
    typedef struct packed {
        npc_sel_t  npc_sel;
        logic      is_branch;
        ext_op_t   ext_op;
        alu_op_t   alu_op;
        logic      alu_src_shamt;
        logic      alu_src_imm;
        logic      mem_write;
        width_t    mem_width;
        logic      reg_write;
        regw_src_t regw_src;
        reg_idx_t  regw_dst;
        tnew_t     tnew;
        tuse_t     rs_tuse;
        tuse_t     rt_tuse;
        reg_idx_t  rs;
        reg_idx_t  rt;
    } ctrl_t;

    // occupancy record for one downstream stage
    typedef struct packed {
        logic     valid;
        logic     reg_write;
        reg_idx_t dst;
        tnew_t    tnew;
    } stage_entry_t;

endpackage

//--- logic/control_decoder.sv
`timescale 1ns/1ns
`include "cpu_params.svh"

module control_decoder import cpu_pkg::*; (
    input  instr_t instr,
    output ctrl_t  ctrl
);

    logic [5:0] opt;
    logic [5:0] funct;
    reg_idx_t   rs_f;
    reg_idx_t   rt_f;
    reg_idx_t   rd_f;

    // one-hot instruction flags
    logic is_r;
    logic i_add;
    logic i_sub;
    logic i_sll;
    logic i_jr;
    logic i_ori;
    logic i_lui;
    logic i_lw;
    logic i_lh;
    logic i_sw;
    logic i_beq;
    logic i_j;
    logic i_jal;

    // class groupings
    logic cal_r;
    logic load;
    logic writes;

    assign opt   = instr[`FIELD_OPT_HI:`FIELD_OPT_LO];
    assign funct = instr[`FIELD_FUNCT_HI:`FIELD_FUNCT_LO];
    assign rs_f  = instr[`FIELD_RS +: 5];
    assign rt_f  = instr[`FIELD_RT +: 5];
    assign rd_f  = instr[`FIELD_RD +: 5];

    assign is_r  = (opt == `OP_RTYPE);
    // signed and unsigned variants share a datapath
    assign i_add = is_r && (funct == `FN_ADD || funct == `FN_ADDU);
    assign i_sub = is_r && (funct == `FN_SUB || funct == `FN_SUBU);
    assign i_sll = is_r && (funct == `FN_SLL);
    assign i_jr  = is_r && (funct == `FN_JR);
    assign i_ori = (opt == `OP_ORI);
    assign i_lui = (opt == `OP_LUI);
    assign i_lw  = (opt == `OP_LW);
    assign i_lh  = (opt == `OP_LH);
    assign i_sw  = (opt == `OP_SW);
    assign i_beq = (opt == `OP_BEQ);
    assign i_j   = (opt == `OP_J);
    assign i_jal = (opt == `OP_JAL);

    assign cal_r  = i_add || i_sub || i_sll;
    assign load   = i_lw || i_lh;
    assign writes = cal_r || i_ori || i_lui || load || i_jal;

    always_comb begin
        // next pc select
        if (i_beq)
            ctrl.npc_sel = 2'd1;
        else if (i_jr)
            ctrl.npc_sel = 2'd2;
        else if (i_j || i_jal)
            ctrl.npc_sel = 2'd3;
        else
            ctrl.npc_sel = 2'd0;
        ctrl.is_branch = i_beq || i_j || i_jal || i_jr;

        // offsets sign extend, lui goes to upper half
        if (i_lui)
            ctrl.ext_op = 2'd2;
        else if (load || i_sw || i_beq)
            ctrl.ext_op = 2'd1;
        else
            ctrl.ext_op = 2'd0;

        // alu op, address calc defaults to add
        if (i_sll)
            ctrl.alu_op = 2'd3;
        else if (i_ori)
            ctrl.alu_op = 2'd2;
        else if (i_sub)
            ctrl.alu_op = 2'd1;
        else
            ctrl.alu_op = 2'd0;
        ctrl.alu_src_shamt = i_sll;
        ctrl.alu_src_imm   = i_ori || load || i_sw;

        // memory side
        ctrl.mem_write = i_sw;
        ctrl.mem_width = i_lh ? 2'd1 : 2'd0;

        // writeback source
        ctrl.reg_write = writes;
        if (i_jal)
            ctrl.regw_src = 2'd3;
        else if (i_lui)
            ctrl.regw_src = 2'd2;
        else if (load)
            ctrl.regw_src = 2'd1;
        else
            ctrl.regw_src = 2'd0;

        // destination resolved here, zero when nothing is written
        if (!writes)
            ctrl.regw_dst = '0;
        else if (i_jal)
            ctrl.regw_dst = `REG_RA;
        else if (cal_r)
            ctrl.regw_dst = rd_f;
        else
            ctrl.regw_dst = rt_f;

        // result-ready time
        if (load)
            ctrl.tnew = 2'd2;
        else if (cal_r || i_ori)
            ctrl.tnew = 2'd1;
        else
            ctrl.tnew = 2'd0;

        // rs use time, branch compare and jr read at decode
        if (i_beq || i_jr)
            ctrl.rs_tuse = 2'd0;
        else if (cal_r || i_ori || load || i_sw)
            ctrl.rs_tuse = 2'd1;
        else
            ctrl.rs_tuse = 2'd3;

        // rt use time, sw store data only needed in memory
        if (i_beq)
            ctrl.rt_tuse = 2'd0;
        else if (cal_r)
            ctrl.rt_tuse = 2'd1;
        else if (i_sw)
            ctrl.rt_tuse = 2'd2;
        else
            ctrl.rt_tuse = 2'd3;

        ctrl.rs = rs_f;
        ctrl.rt = rt_f;
    end

endmodule

//--- logic/pipeline_tracker.sv
`timescale 1ns/1ns

module pipeline_tracker import cpu_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         instr_valid,
    input  logic         stall,
    input  ctrl_t        ctrl,
    output stage_entry_t ex_entry,
    output stage_entry_t mem_entry,
    output stage_entry_t wb_entry
);

    logic         accept;
    stage_entry_t dec_entry;
    stage_entry_t ex_next;
    stage_entry_t mem_next;
    stage_entry_t wb_next;

    // decode advances only on a valid, unstalled cycle
    assign accept = instr_valid && !stall;

    always_comb begin
        // entry built from the current decode
        dec_entry.valid     = 1'b1;
        dec_entry.reg_write = ctrl.reg_write;
        dec_entry.dst       = ctrl.regw_dst;
        dec_entry.tnew      = ctrl.tnew;

        // bubble into execute when decode holds
        ex_next = accept ? dec_entry : '0;

        // one cycle closer to ready
        mem_next = ex_entry;
        if (ex_entry.tnew != 2'd0)
            mem_next.tnew = ex_entry.tnew - 2'd1;

        // everything in writeback is ready
        wb_next      = mem_entry;
        wb_next.tnew = 2'd0;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_entry  <= '0;
            mem_entry <= '0;
            wb_entry  <= '0;
        end else begin
            // chain always shifts, no internal hold
            ex_entry  <= ex_next;
            mem_entry <= mem_next;
            wb_entry  <= wb_next;
        end
    end

endmodule

//--- logic/hazard_resolver.sv
`timescale 1ns/1ns

module hazard_resolver import cpu_pkg::*; (
    input  ctrl_t        ctrl,
    input  stage_entry_t ex_entry,
    input  stage_entry_t mem_entry,
    input  stage_entry_t wb_entry,
    output logic         stall,
    output fwd_sel_t     fwd_rs,
    output fwd_sel_t     fwd_rt
);

    logic rs_stall;
    logic rt_stall;

    // live writer of src in this stage, r0 excluded
    function automatic logic hits(input stage_entry_t e, input reg_idx_t src);
        hits = e.valid && e.reg_write && (e.dst == src) && (src != '0);
    endfunction

    // returns {stall, select} for one source operand
    function automatic logic [2:0] resolve(
        input reg_idx_t     src,
        input tuse_t        tuse,
        input stage_entry_t ex_e,
        input stage_entry_t mem_e,
        input stage_entry_t wb_e
    );
        logic     found;
        tnew_t    t;
        fwd_sel_t sel;
        begin
            found = 1'b0;
            t     = 2'd0;
            sel   = 2'd0;
            // operand never read
            if (tuse != 2'd3) begin
                // youngest producer wins
                if (hits(ex_e, src)) begin
                    found = 1'b1;
                    t     = ex_e.tnew;
                    sel   = 2'd1;
                end else if (hits(mem_e, src)) begin
                    found = 1'b1;
                    t     = mem_e.tnew;
                    sel   = 2'd2;
                end else if (hits(wb_e, src)) begin
                    found = 1'b1;
                    t     = wb_e.tnew;
                    sel   = 2'd3;
                end
            end
            // result arrives too late
            if (found && (t > tuse))
                resolve = {1'b1, 2'd0};
            else
                resolve = {1'b0, sel};
        end
    endfunction

    assign {rs_stall, fwd_rs} = resolve(ctrl.rs, ctrl.rs_tuse, ex_entry, mem_entry, wb_entry);
    assign {rt_stall, fwd_rt} = resolve(ctrl.rt, ctrl.rt_tuse, ex_entry, mem_entry, wb_entry);

    // either operand holds decode
    assign stall = rs_stall || rt_stall;

endmodule

//--- logic/decode_hazard_top.sv
`timescale 1ns/1ns

module decode_hazard_top import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     instr_valid,
    input  instr_t   instr,
    output ctrl_t    ctrl,
    output logic     stall,
    output fwd_sel_t fwd_rs,
    output fwd_sel_t fwd_rt
);

    // tracked downstream stages
    stage_entry_t ex_entry;
    stage_entry_t mem_entry;
    stage_entry_t wb_entry;

    // instruction word to control bundle
    control_decoder u_decoder (
        .instr (instr),
        .ctrl  (ctrl)
    );

    // stall feeds back so held decode injects a bubble
    pipeline_tracker u_tracker (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .stall       (stall),
        .ctrl        (ctrl),
        .ex_entry    (ex_entry),
        .mem_entry   (mem_entry),
        .wb_entry    (wb_entry)
    );

    // tuse against tracked tnew
    hazard_resolver u_resolver (
        .ctrl      (ctrl),
        .ex_entry  (ex_entry),
        .mem_entry (mem_entry),
        .wb_entry  (wb_entry),
        .stall     (stall),
        .fwd_rs    (fwd_rs),
        .fwd_rt    (fwd_rt)
    );

endmodule

//--- verification/tb_decode_hazard.sv
`timescale 1ns/1ns
`include "cpu_params.svh"

module tb_decode_hazard import cpu_pkg::*; ();

    localparam int MAX_RECORDS = 128;

    // one replay record with fields in file order from the top hex digit
    typedef struct packed {
        logic [7:0] test_id;
        logic [3:0] valid;
        instr_t     instr;
        logic [3:0] stall;
        logic [3:0] fwd_rs;
        logic [3:0] fwd_rt;
        logic [3:0] npc_sel;
        logic [3:0] alu_op;
        logic [3:0] regw_src;
        logic [7:0] regw_dst;
        logic [3:0] reg_write;
    } pattern_t;

    // dut side
    logic     clk;
    logic     rst_n;
    logic     instr_valid;
    instr_t   instr;
    ctrl_t    ctrl;
    logic     stall;
    fwd_sel_t fwd_rs;
    fwd_sel_t fwd_rt;

    // replay state
    logic [79:0] pattern_mem [0:MAX_RECORDS-1];
    pattern_t    rec;
    int          rec_count;
    int          rec_index;
    bit          setup_ok;
    int          timeout_limit = 0;
    int          cycle_count = 0;

    // bookkeeping
    logic [7:0]  cur_test;
    int          test_errors;
    int          test_cycles;
    int          tests_run;
    int          tests_failed;
    int          total_errors;
    int          total_checks;

    decode_hazard_top dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .ctrl        (ctrl),
        .stall       (stall),
        .fwd_rs      (fwd_rs),
        .fwd_rt      (fwd_rt)
    );

    // 20 ns period
    always #10 clk = ~clk;

    // runaway guard
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
            $display("timeout: pattern replay still running after %0d cycles", cycle_count);
            $display("Done: errors found");
            $finish;
        end
    end

    // one observed field against its expected value
    task automatic compare_field(input string name, input logic [7:0] expected,
                                 input logic [7:0] actual);
        total_checks++;
        assert (actual === expected) else begin
            $display("[ERROR] %s: expected %h, actual %h (test %0d, record %0d, instr %h, op %h)",
                     name, expected, actual, cur_test, rec_index, rec.instr,
                     rec.instr[`FIELD_OPT_HI:`FIELD_OPT_LO]);
            test_errors++;
            total_errors++;
        end
    endtask

    // immediate and memory selects by opcode class
    task automatic check_datapath_selects();
        logic [5:0] op;
        logic [5:0] fn;
        op = rec.instr[`FIELD_OPT_HI:`FIELD_OPT_LO];
        fn = rec.instr[`FIELD_FUNCT_HI:`FIELD_FUNCT_LO];
        // any pc redirect counts as a branch
        compare_field("is_branch", 8'(rec.npc_sel != 4'd0), 8'(ctrl.is_branch));
        compare_field("mem_write", 8'(op == `OP_SW), 8'(ctrl.mem_write));
        case (op)
            `OP_ORI: begin
                // ori zero extends
                compare_field("ext_op", 8'h00, 8'(ctrl.ext_op));
                compare_field("alu_src_imm", 8'h01, 8'(ctrl.alu_src_imm));
            end
            `OP_LUI: begin
                compare_field("ext_op", 8'h02, 8'(ctrl.ext_op));
            end
            `OP_LW, `OP_LH, `OP_SW: begin
                compare_field("ext_op", 8'h01, 8'(ctrl.ext_op));
                compare_field("alu_src_imm", 8'h01, 8'(ctrl.alu_src_imm));
                compare_field("mem_width", (op == `OP_LH) ? 8'h01 : 8'h00,
                              8'(ctrl.mem_width));
            end
            `OP_BEQ: begin
                compare_field("ext_op", 8'h01, 8'(ctrl.ext_op));
            end
            `OP_RTYPE: begin
                // register operands only, shamt for sll
                compare_field("alu_src_imm", 8'h00, 8'(ctrl.alu_src_imm));
                compare_field("alu_src_shamt", 8'(fn == `FN_SLL), 8'(ctrl.alu_src_shamt));
            end
            default: ;
        endcase
    endtask

    // hazard outputs first and then the decoded selects
    task automatic check_outputs();
        compare_field("stall", 8'(rec.stall), 8'(stall));
        compare_field("fwd_rs", 8'(rec.fwd_rs), 8'(fwd_rs));
        compare_field("fwd_rt", 8'(rec.fwd_rt), 8'(fwd_rt));
        compare_field("npc_sel", 8'(rec.npc_sel), 8'(ctrl.npc_sel));
        compare_field("alu_op", 8'(rec.alu_op), 8'(ctrl.alu_op));
        compare_field("regw_src", 8'(rec.regw_src), 8'(ctrl.regw_src));
        compare_field("regw_dst", rec.regw_dst, 8'(ctrl.regw_dst));
        compare_field("reg_write", 8'(rec.reg_write), 8'(ctrl.reg_write));
        check_datapath_selects();
    endtask

    // summary line for the test just closed
    task automatic report_test();
        tests_run++;
        if (test_errors != 0)
            tests_failed++;
        $display("test %0d: %s after %0d cycles, %0d mismatches", cur_test,
                 (test_errors == 0) ? "pass" : "FAIL", test_cycles, test_errors);
        test_errors = 0;
        test_cycles = 0;
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        instr_valid  = 1'b0;
        instr        = '0;
        setup_ok     = 1'b0;
        rec_count    = 0;
        cur_test     = '0;
        test_errors  = 0;
        test_cycles  = 0;
        tests_run    = 0;
        tests_failed = 0;
        total_errors = 0;
        total_checks = 0;

        $readmemh("verification/hazard_patterns.mem", pattern_mem);

        // list ends at the first record with test number ff
        for (rec_index = 0; rec_index < MAX_RECORDS; rec_index++) begin
            if (!setup_ok && pattern_mem[rec_index[6:0]][79:72] === 8'hff) begin
                rec_count = rec_index;
                setup_ok  = 1'b1;
            end
        end
        if (!setup_ok || rec_count == 0) begin
            $display("pattern file holds no records or lacks its end marker");
            setup_ok = 1'b0;
        end
        timeout_limit = 2 * rec_count + 20;

        // 4 reset edges then release off the edge
        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;

        if (setup_ok) begin
            cur_test = pattern_mem[0][79:72];
            for (rec_index = 0; rec_index < rec_count; rec_index++) begin
                rec = pattern_mem[rec_index[6:0]];
                if (rec.test_id != cur_test) begin
                    report_test();
                    cur_test = rec.test_id;
                end
                // stalled records repeat the held instruction
                instr_valid = rec.valid[0];
                instr       = rec.instr;
                // sample just ahead of the next edge
                #16;
                check_outputs();
                test_cycles++;
                @(posedge clk);
                #2;
            end
            report_test();
        end

        $display("%0d tests run, %0d failed, %0d of %0d checks failed",
                 tests_run, tests_failed, total_errors, total_checks);
        if (setup_ok && total_errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

//--- all.f
+incdir+include
logic/cpu_pkg.sv
logic/control_decoder.sv
logic/pipeline_tracker.sv
logic/hazard_resolver.sv
logic/decode_hazard_top.sv
verification/tb_decode_hazard.sv

//--- run.sh
#!/bin/sh
# build and run the decode hazard testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f all.f \
    --top-module tb_decode_hazard \
    -o sim_decode_hazard

./obj_dir/sim_decode_hazard > sim.log 2>&1
cat sim.log

if grep -qx "Done: no errors" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

//--- verification/hazard_patterns.mem
// test(2) valid(1) instr(8) stall(1) fwd_rs(1) fwd_rt(1) npc_sel(1) alu_op(1) regw_src(1)
// regw_dst(2) reg_write(1), one record per cycle, test ff ends the list
// reset state then add, sub, ori, lui with no dependencies
011002250200000000a1
011006458220000100b1
01134AC00FF0000200c1
0113C0D12340000020d1
// every instruction class, bubbles in between
02100228020000000101
02000000000000030001
02100228821000000111
02000000000000030001
02100229022000010121
02000000000000030001
02100229823000010131
02000000000000030001
0210002A100000030141
02000000000000030001
02134355A5A000020151
02000000000000030001
0213C16BEEF000002161
02000000000000030001
0218C370008000001171
02000000000000030001
021AC22000C000000000
02000000000000030001
0218438FFFE000001181
02000000000000030001
02110220004000100000
02000000000000030001
02108000100000300000
02000000000000030001
0210C0002000003031f1
02000000000000030001
02100200008000200000
// lw r5 then add reading r5, one held cycle
0318C850000000001051
03100A73020100000061
03100A73020020000061
// sub then beq, lw then beq, jal then jr r31
04100224022000010081
04111000010100100000
04111000010020100000
0418C690004000001091
0411009FFFC100100000
0411009FFFC100100000
0411009FFFC003100000
0410C0000400003031f1
04103E00008010200000
// two writers of r14, then writes to r0
051346E00010000200e1
0513C0E00030000020e1
05101CE78200110000f1
05100220021000000001
0518C200000000001001
05100008020000000101
// sw store data forwarded with tuse 2
0618C740000000001141
0610022A021000000141
061AC740000001000000
0618C750004000001151
061AC750008001000000
ff000000000000000000
